// ==== hdl/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// ------------------------------------------------------------
// Program counter
// ------------------------------------------------------------

// First fetch address after reset
`define FETCH_RESET_PC 32'h3000_0000

// Sequential step, one 32-bit instruction
`define FETCH_PC_STEP 32'd4

// ------------------------------------------------------------
// Decode and bus response
// ------------------------------------------------------------

`define FETCH_OPCODE_JAL 7'b110_1111

// Any other rresp code parks the stage in fault
`define FETCH_RESP_OKAY 2'b00

`endif

// ==== hdl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // ------------------------------------------------------------
    // J-type instruction layout
    // ------------------------------------------------------------

    // Immediate bits are scattered, see inst_predecoder for reassembly
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jtype_fields_t;

    // ------------------------------------------------------------
    // Fetched instruction word
    // ------------------------------------------------------------

    // Same 32 bits, seen either raw or as J-type fields
    typedef union packed {
        logic [31:0]   raw;
        jtype_fields_t jtype;
    } inst_word_u;

endpackage

`default_nettype wire

// ==== hdl/fetch_control.sv ====
`default_nettype none

module fetch_control (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     read_done,
    input  wire  [31:0]             read_data,
    input  wire                     read_error,
    input  wire                     inst_ready,
    input  wire  [31:0]             pc,
    input  wire                     redirect_pending,
    output logic                    read_start,
    output logic                    advance,
    output logic                    recover,
    output logic                    inst_valid,
    output fetch_pkg::inst_word_u   inst,
    output logic [31:0]             inst_pc,
    output logic                    fault,
    output logic [31:0]             fault_pc
);

    // State encodings
    localparam logic [2:0] st_start   = 3'd0;
    localparam logic [2:0] st_request = 3'd1;
    localparam logic [2:0] st_wait    = 3'd2;
    localparam logic [2:0] st_present = 3'd3;
    localparam logic [2:0] st_fault   = 3'd4;

    logic [2:0] state;
    logic [2:0] state_next;

    // Read in flight, set by the start and cleared by the response
    logic       outstanding;

    // ------------------------------------------------------------
    // Decoded controls
    // ------------------------------------------------------------

    // Start and request both issue a read at the current pc
    assign read_start = (state == st_start) || (state == st_request);
    assign inst_valid = (state == st_present);
    assign fault      = (state == st_fault);
    assign advance    = (state == st_present) && inst_ready;
    assign recover    = (state == st_fault) && redirect_pending;

    always_comb begin
        state_next = state;
        case (state)
            st_start,
            st_request: begin
                state_next = st_wait;
            end
            st_wait: begin
                if (read_done) begin
                    state_next = read_error ? st_fault : st_present;
                end
            end
            st_present: begin
                if (inst_ready) begin
                    state_next = st_request;
                end
            end
            st_fault: begin
                // Parked until a redirect shows up
                if (redirect_pending) begin
                    state_next = st_request;
                end
            end
            default: begin
                state_next = st_start;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_start;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (read_start) begin
            outstanding <= 1'b1;
        end else if (read_done) begin
            outstanding <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Instruction and fault capture
    // ------------------------------------------------------------

    // pc is still the fetch address while the read is in flight
    always_ff @(posedge clock) begin
        if (state == st_wait && read_done) begin
            if (read_error) begin
                fault_pc <= pc;
            end else begin
                inst.raw <= read_data;
                inst_pc  <= pc;
            end
        end
    end

    hold_inst_stable: assert property (
        @(posedge clock) disable iff (reset)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst) && $stable(inst_pc)
    );

    // One read at a time, none while waiting on a response
    no_start_in_wait: assert property (
        @(posedge clock) disable iff (reset)
        outstanding |-> !read_start
    );

endmodule

`default_nettype wire

// ==== hdl/pc_generator.sv ====
`default_nettype none

`include "fetch_settings.svh"

module pc_generator (
    input  wire         clock,
    input  wire         reset,
    input  wire         advance,
    input  wire         recover,
    input  wire         redirect_valid,
    input  wire  [31:0] redirect_pc,
    input  wire         hold,
    input  wire         jal_take,
    input  wire  [31:0] jal_target,
    output logic [31:0] pc,
    output logic        redirect_pending
);

    logic        redirect_q;
    logic [31:0] redirect_pc_q;
    logic        hold_q;
    logic        take_redirect;
    logic        take_hold;
    logic [31:0] sel_redirect_pc;
    logic [31:0] pc_next;

    // A request arriving this cycle counts as already latched
    assign take_redirect    = redirect_valid || redirect_q;
    assign take_hold        = hold || hold_q;
    assign redirect_pending = take_redirect;

    // Newest redirect wins, low bits forced to a word boundary
    assign sel_redirect_pc = redirect_valid ? {redirect_pc[31:2], 2'b00} : redirect_pc_q;

    // ------------------------------------------------------------
    // Next pc priority
    // ------------------------------------------------------------

    always_comb begin
        pc_next = pc + `FETCH_PC_STEP;
        if (recover) begin
            pc_next = sel_redirect_pc;
        end else if (take_hold) begin
            pc_next = pc;
        end else if (take_redirect) begin
            pc_next = sel_redirect_pc;
        end else if (jal_take) begin
            pc_next = jal_target;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc         <= `FETCH_RESET_PC;
            redirect_q <= 1'b0;
            hold_q     <= 1'b0;
        end else begin
            if (advance || recover) begin
                pc <= pc_next;
            end
            if (recover) begin
                redirect_q <= 1'b0;
                hold_q     <= 1'b0;
            end else if (advance) begin
                // A hold consumes this transfer, the redirect waits for the next one
                hold_q     <= 1'b0;
                redirect_q <= take_hold && take_redirect;
            end else begin
                if (redirect_valid) begin
                    redirect_q <= 1'b1;
                end
                if (hold) begin
                    hold_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (redirect_valid) begin
            redirect_pc_q <= {redirect_pc[31:2], 2'b00};
        end
    end

    pc_word_aligned: assert property (
        @(posedge clock) disable iff (reset)
        pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// ==== hdl/axi_read_port.sv ====
`default_nettype none

`include "fetch_settings.svh"

module axi_read_port (
    input  wire         clock,
    input  wire         reset,
    input  wire         read_start,
    input  wire  [31:0] read_addr,
    input  wire         arready,
    input  wire         rvalid,
    input  wire  [31:0] rdata,
    input  wire  [1:0]  rresp,
    output logic        arvalid,
    output logic [31:0] araddr,
    output logic        rready,
    output logic        read_done,
    output logic [31:0] read_data,
    output logic        read_error
);

    // ------------------------------------------------------------
    // Address channel and outstanding read
    // ------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else begin
            if (read_start) begin
                arvalid <= 1'b1;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
            end

            // rready marks the single read in flight
            if (arvalid && arready) begin
                rready <= 1'b1;
            end else if (rvalid && rready) begin
                rready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (read_start) begin
            araddr <= read_addr;
        end
    end

    // Response decode, seen by control in the beat cycle
    assign read_done  = rvalid && rready;
    assign read_data  = rdata;
    assign read_error = (rresp != `FETCH_RESP_OKAY);

    araddr_stable: assert property (
        @(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

    no_stray_rvalid: assert property (
        @(posedge clock) disable iff (reset)
        rvalid |-> rready
    );

endmodule

`default_nettype wire

// ==== hdl/inst_predecoder.sv ====
`default_nettype none

`include "fetch_settings.svh"

module inst_predecoder (
    input  wire fetch_pkg::inst_word_u inst,
    input  wire [31:0]                 inst_pc,
    output logic                       jal_take,
    output logic [31:0]                jal_target
);

    fetch_pkg::jtype_fields_t fields;
    logic                     is_jal;
    logic [31:0]              imm;
    logic [31:0]              target;

    assign fields = inst.jtype;

    // ------------------------------------------------------------
    // J-type immediate
    // ------------------------------------------------------------

    // imm[20|10:1|11|19:12], bit 0 always zero
    assign imm = {
        {11{fields.imm_20}},
        fields.imm_20,
        fields.imm_19_12,
        fields.imm_11,
        fields.imm_10_1,
        1'b0
    };

    assign target = inst_pc + imm;
    assign is_jal = (fields.opcode == `FETCH_OPCODE_JAL);

    // No compressed support, so a halfword target is left to the
    // later stages to trap on
    assign jal_take   = is_jal && (target[1:0] == 2'b00);
    assign jal_target = target;

endmodule

`default_nettype wire

// ==== hdl/fetch_unit_top.sv ====
`default_nettype none

module fetch_unit_top (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   redirect_valid,
    input  wire [31:0]            redirect_pc,
    input  wire                   hold,
    input  wire                   inst_ready,
    input  wire                   arready,
    input  wire                   rvalid,
    input  wire [31:0]            rdata,
    input  wire [1:0]             rresp,
    output wire                   inst_valid,
    output fetch_pkg::inst_word_u inst,
    output wire [31:0]            inst_pc,
    output wire                   fault,
    output wire [31:0]            fault_pc,
    output wire                   arvalid,
    output wire [31:0]            araddr,
    output wire                   rready
);

    // ------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------

    logic        read_start;
    logic        read_done;
    logic [31:0] read_data;
    logic        read_error;
    logic        advance;
    logic        recover;
    logic [31:0] pc;
    logic        redirect_pending;
    logic        jal_take;
    logic [31:0] jal_target;

    fetch_control u_fetch_control (
        .clock            (clock),
        .reset            (reset),
        .read_done        (read_done),
        .read_data        (read_data),
        .read_error       (read_error),
        .inst_ready       (inst_ready),
        .pc               (pc),
        .redirect_pending (redirect_pending),
        .read_start       (read_start),
        .advance          (advance),
        .recover          (recover),
        .inst_valid       (inst_valid),
        .inst             (inst),
        .inst_pc          (inst_pc),
        .fault            (fault),
        .fault_pc         (fault_pc)
    );

    pc_generator u_pc_generator (
        .clock            (clock),
        .reset            (reset),
        .advance          (advance),
        .recover          (recover),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .hold             (hold),
        .jal_take         (jal_take),
        .jal_target       (jal_target),
        .pc               (pc),
        .redirect_pending (redirect_pending)
    );

    // Bus side, fetch address comes straight from the pc register
    axi_read_port u_axi_read_port (
        .clock      (clock),
        .reset      (reset),
        .read_start (read_start),
        .read_addr  (pc),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rresp      (rresp),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .read_done  (read_done),
        .read_data  (read_data),
        .read_error (read_error)
    );

    // Looks at the presented word, used at the transfer
    inst_predecoder u_inst_predecoder (
        .inst       (inst),
        .inst_pc    (inst_pc),
        .jal_take   (jal_take),
        .jal_target (jal_target)
    );

endmodule

`default_nettype wire

// ==== dv/fetch_tb.sv ====
`default_nettype none

`include "fetch_settings.svh"

module fetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 64;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  redirect_valid;
    logic [31:0]           redirect_pc;
    logic                  hold;
    logic                  inst_ready;
    logic                  arready;
    logic                  rvalid;
    logic [31:0]           rdata;
    logic [1:0]            rresp;
    logic                  inst_valid;
    fetch_pkg::inst_word_u inst;
    logic [31:0]           inst_pc;
    logic                  fault;
    logic [31:0]           fault_pc;
    logic                  arvalid;
    logic [31:0]           araddr;
    logic                  rready;

    // Pc of the next instruction the stage should deliver
    logic [31:0] next_pc;

    // Memory model overrides and read latencies
    logic [31:0] special_addr [0:3];
    logic [31:0] special_data [0:3];
    logic        special_error [0:3];
    int          special_count = 0;
    int unsigned latency_table [0:63];
    int unsigned beat_count = 0;

    // Address channel back-pressure, one bit per cycle
    logic        arready_table [0:63];
    int unsigned ar_cycle = 0;

    fetch_unit_top uut (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .hold           (hold),
        .inst_ready     (inst_ready),
        .arready        (arready),
        .rvalid         (rvalid),
        .rdata          (rdata),
        .rresp          (rresp),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .fault          (fault),
        .fault_pc       (fault_pc),
        .arvalid        (arvalid),
        .araddr         (araddr),
        .rready         (rready)
    );

    always #2 clock = ~clock;

    // ------------------------------------------------------------
    // Memory model
    // ------------------------------------------------------------

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] model_data(input logic [31:0] addr);
        logic [31:0] word;
        word = mem_word(addr);
        for (int i = 0; i < special_count; i++) begin
            if (special_addr[i] == addr) begin
                word = special_data[i];
            end
        end
        return word;
    endfunction

    function automatic logic model_error(input logic [31:0] addr);
        logic is_error;
        is_error = 1'b0;
        for (int i = 0; i < special_count; i++) begin
            if (special_addr[i] == addr) begin
                is_error = special_error[i];
            end
        end
        return is_error;
    endfunction

    // JAL with rd = x1, immediate scattered as imm[20|10:1|11|19:12]
    function automatic logic [31:0] jal_word(input logic [31:0] offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], 5'd1, `FETCH_OPCODE_JAL};
    endfunction

    task automatic add_special(input logic [31:0] addr, input logic [31:0] data,
                               input logic is_error);
        special_addr[special_count]  = addr;
        special_data[special_count]  = data;
        special_error[special_count] = is_error;
        special_count = special_count + 1;
    endtask

    // arready changes just after the rising edge
    initial begin : ar_backpressure
        arready = 1'b1;
        forever begin
            @(posedge clock);
            #1;
            arready  = arready_table[ar_cycle % 64];
            ar_cycle = ar_cycle + 1;
        end
    end

    // AXI slave, address sampled at the falling edge before the handshake
    initial begin : axi_slave
        logic [31:0] addr;
        int unsigned latency;
        rvalid  = 1'b0;
        rdata   = 32'h0;
        rresp   = 2'b00;
        forever begin
            @(negedge clock);
            if (arvalid && arready) begin
                addr       = araddr;
                latency    = latency_table[beat_count % 64];
                beat_count = beat_count + 1;
                @(posedge clock);
                repeat (latency) @(posedge clock);
                #1;
                rvalid = 1'b1;
                rdata  = model_data(addr);
                rresp  = model_error(addr) ? 2'b10 : 2'b00;
                @(posedge clock);
                #1;
                rvalid = 1'b0;
                rresp  = 2'b00;
            end
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        stop_on_failure();
    endtask

    task automatic compare_inst(input fetch_pkg::inst_word_u got, input logic [31:0] got_pc,
                                input fetch_pkg::inst_word_u exp, input logic [31:0] exp_pc);
        if (got !== exp || got_pc !== exp_pc) begin
            $display("error at %0t: inst %08h pc %08h, expected inst %08h pc %08h",
                     $time, got.raw, got_pc, exp.raw, exp_pc);
            stop_on_failure();
        end
    endtask

    task automatic compare_fault(input logic [31:0] got_pc, input logic [31:0] exp_pc);
        if (got_pc !== exp_pc) begin
            $display("error at %0t: fault_pc %08h, expected %08h", $time, got_pc, exp_pc);
            stop_on_failure();
        end
    endtask

    task automatic compare_addr(input logic [31:0] got_addr, input logic [31:0] exp_addr);
        if (got_addr !== exp_addr) begin
            $display("error at %0t: araddr %08h, expected %08h", $time, got_addr, exp_addr);
            stop_on_failure();
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // ------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic pulse_controls(input logic do_hold, input logic do_redirect,
                                  input logic [31:0] target);
        hold           = do_hold;
        redirect_valid = do_redirect;
        redirect_pc    = target;
        next_cycle();
        hold           = 1'b0;
        redirect_valid = 1'b0;
    endtask

    // Waits for the next instruction, keeps it stalled a while, then takes it
    task automatic take_inst(input logic [31:0] exp_pc, input int unsigned max_stall);
        fetch_pkg::inst_word_u exp_word;
        int unsigned           stall;
        int unsigned           waited;
        exp_word.raw = model_data(exp_pc);
        stall        = (max_stall == 0) ? 0 : $urandom_range(max_stall, 0);
        waited       = 0;
        while (!inst_valid) begin
            if (waited == wait_limit) begin
                report_timeout($sformatf("inst_valid with pc %08h", exp_pc));
            end
            next_cycle();
            waited = waited + 1;
        end
        repeat (stall) begin
            compare_inst(inst, inst_pc, exp_word, exp_pc);
            next_cycle();
            compare_flag("inst_valid under back-pressure", inst_valid, 1'b1);
        end
        compare_inst(inst, inst_pc, exp_word, exp_pc);
        inst_ready = 1'b1;
        next_cycle();
        inst_ready = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------

    task automatic sequential_fetch();
        for (int i = 0; i < 10; i++) begin
            take_inst(next_pc, 0);
            next_pc = next_pc + 4;
        end
    endtask

    task automatic back_pressure();
        for (int i = 0; i < 10; i++) begin
            take_inst(next_pc, 6);
            next_pc = next_pc + 4;
        end
    endtask

    task automatic redirect_flow();
        logic [31:0] target;
        target = 32'h3000_0400;
        pulse_controls(1'b0, 1'b1, target);
        // The fetch already in flight still comes out first
        take_inst(next_pc, 0);
        take_inst(target, 0);
        take_inst(target + 4, 0);
        take_inst(target + 8, 0);
        next_pc = target + 12;
    endtask

    task automatic jal_follow();
        logic [31:0] base;
        logic [31:0] fwd_addr;
        logic [31:0] fwd_dest;
        logic [31:0] back_addr;
        logic [31:0] back_dest;
        base      = 32'h3000_1000;
        fwd_addr  = base + 8;
        fwd_dest  = fwd_addr + 32'h0001_0840;
        back_addr = fwd_dest + 4;
        // Minus 0x820
        back_dest = back_addr + 32'hffff_f7e0;
        add_special(fwd_addr, jal_word(32'h0001_0840), 1'b0);
        add_special(back_addr, jal_word(32'hffff_f7e0), 1'b0);
        pulse_controls(1'b0, 1'b1, base);
        take_inst(next_pc, 0);
        take_inst(base, 0);
        take_inst(base + 4, 0);
        take_inst(fwd_addr, 0);
        take_inst(fwd_dest, 0);
        take_inst(back_addr, 0);
        take_inst(back_dest, 0);
        take_inst(back_dest + 4, 0);
        next_pc = back_dest + 8;
    endtask

    task automatic hold_repeat();
        logic [31:0] first;
        logic [31:0] target;
        first  = next_pc;
        target = 32'h3000_2000;
        pulse_controls(1'b1, 1'b0, 32'h0);
        take_inst(first, 0);
        take_inst(first, 0);
        take_inst(first + 4, 0);
        // Hold wins first, the redirect lands one transfer later
        pulse_controls(1'b1, 1'b1, target);
        take_inst(first + 8, 0);
        take_inst(first + 8, 0);
        take_inst(target, 0);
        take_inst(target + 4, 0);
        next_pc = target + 8;
    endtask

    task automatic fault_recovery();
        logic [31:0] bad_base;
        logic [31:0] resume;
        int unsigned waited;
        bad_base = 32'h3000_3000;
        resume   = 32'h3000_4000;
        waited   = 0;
        add_special(bad_base + 8, mem_word(bad_base + 8), 1'b1);
        pulse_controls(1'b0, 1'b1, bad_base);
        take_inst(next_pc, 0);
        take_inst(bad_base, 0);
        take_inst(bad_base + 4, 0);
        while (!fault) begin
            compare_flag("inst_valid after an error response", inst_valid, 1'b0);
            if (waited == wait_limit) begin
                report_timeout("fault after an error response");
            end
            next_cycle();
            waited = waited + 1;
        end
        compare_fault(fault_pc, bad_base + 8);
        repeat (5) begin
            next_cycle();
            compare_flag("fault while parked", fault, 1'b1);
            compare_flag("inst_valid while parked", inst_valid, 1'b0);
            compare_flag("arvalid while parked", arvalid, 1'b0);
        end
        pulse_controls(1'b0, 1'b1, resume);
        compare_flag("fault after the redirect", fault, 1'b0);
        next_cycle();
        compare_flag("arvalid after the redirect", arvalid, 1'b1);
        compare_addr(araddr, resume);
        take_inst(resume, 0);
        take_inst(resume + 4, 0);
        next_pc = resume + 8;
    endtask

    initial begin : stimulus
        reset          = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = 32'h0;
        hold           = 1'b0;
        inst_ready     = 1'b0;
        next_pc        = `FETCH_RESET_PC;
        void'($urandom(32'h1ece_01ef));
        for (int i = 0; i < 64; i++) begin
            latency_table[i] = $urandom_range(5, 0);
        end
        for (int i = 0; i < 64; i++) begin
            arready_table[i] = ($urandom_range(3, 0) != 0);
        end
        repeat (8) @(posedge clock);
        #1;
        compare_flag("inst_valid in reset", inst_valid, 1'b0);
        compare_flag("arvalid in reset", arvalid, 1'b0);
        compare_flag("rready in reset", rready, 1'b0);
        compare_flag("fault in reset", fault, 1'b0);
        reset = 1'b0;
        next_cycle();
        compare_flag("first arvalid after reset", arvalid, 1'b1);
        compare_addr(araddr, `FETCH_RESET_PC);

        sequential_fetch();
        back_pressure();
        redirect_flow();
        jal_follow();
        hold_repeat();
        fault_recovery();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_control.sv
hdl/pc_generator.sv
hdl/axi_read_port.sv
hdl/inst_predecoder.sv
hdl/fetch_unit_top.sv
dv/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/fetch_control.sv
      - hdl/pc_generator.sv
      - hdl/axi_read_port.sv
      - hdl/inst_predecoder.sv
      - hdl/fetch_unit_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/fetch_tb.sv
